// ==== weight_rot_pkg.sv ====
`default_nettype none

package weight_rot_pkg;

  // header field widths and bank address width
  localparam int BITS_KH2    = 2;
  localparam int BITS_CIN    = 4;
  localparam int BITS_COLS   = 4;
  localparam int BITS_BLOCKS = 4;
  localparam int BITS_ADDR   = 6;

  typedef logic [BITS_KH2-1:0]    kh2_t;     // half kernel height, also used for kw2
  typedef logic [BITS_KH2:0]      kh_t;      // runs 2*kh2 down to 0
  typedef logic [BITS_CIN-1:0]    cin_t;     // input channels - 1
  typedef logic [BITS_COLS-1:0]   cols_t;    // image columns - 1
  typedef logic [BITS_BLOCKS-1:0] blocks_t;  // image blocks - 1
  typedef logic [BITS_ADDR-1:0]   addr_t;    // bank address or beat count

  // sideband layout of the output stream
  localparam int TUSER_WIDTH       = 7;
  localparam int I_KW2             = 0;  // two bits wide
  localparam int I_IS_W_FIRST      = 2;
  localparam int I_IS_CIN_LAST     = 3;
  localparam int I_IS_COLS_1_K2    = 4;
  localparam int I_IS_TOP_BLOCK    = 5;
  localparam int I_IS_BOTTOM_BLOCK = 6;

  typedef logic [TUSER_WIDTH-1:0] tuser_t;

  // write side fsm
  typedef enum logic [1:0] {W_IDLE, W_GET_REF, W_WRITE, W_SWITCH} w_state_e;

  // read side fsm
  typedef enum logic [1:0] {R_IDLE, R_READ, R_SWITCH} r_state_e;

endpackage

`default_nettype wire

// ==== weight_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_bank #(
  parameter int DATA_WIDTH = 32,
  parameter int DEPTH      = 48
) (
  input  wire                             aclk,
  input  wire                             i_rst_n,
  input  wire                             i_ref_en,
  input  wire                             i_wr_en,
  input  wire                             i_rd_en,
  input  wire  [DATA_WIDTH-1:0]           i_data,
  input  wire  weight_rot_pkg::kh2_t      i_kw2,
  input  wire  weight_rot_pkg::kh2_t      i_kh2,
  input  wire  weight_rot_pkg::cin_t      i_cin_1,
  input  wire  weight_rot_pkg::cols_t     i_cols_1,
  input  wire  weight_rot_pkg::blocks_t   i_blocks_1,
  output logic [DATA_WIDTH-1:0]           o_rd_data,
  output weight_rot_pkg::kh2_t            o_kw2,
  output weight_rot_pkg::kh2_t            o_kh2,
  output weight_rot_pkg::cin_t            o_cin_1,
  output weight_rot_pkg::cols_t           o_cols_1,
  output weight_rot_pkg::blocks_t         o_blocks_1
);

  // one bit wider than an address so an oversized kernel shows up
  typedef logic [weight_rot_pkg::BITS_ADDR:0] beat_t;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  weight_rot_pkg::addr_t wr_ptr;
  weight_rot_pkg::addr_t rd_ptr;
  weight_rot_pkg::addr_t beats;  // words per kernel
  beat_t                 kh_len;
  beat_t                 cin_len;
  beat_t                 beat_cnt;

  // beats = (2*kh2+1) * (cin_1+1)
  assign kh_len   = beat_t'({o_kh2, 1'b1});
  assign cin_len  = beat_t'(o_cin_1) + beat_t'(1);
  assign beat_cnt = kh_len * cin_len;
  assign beats    = weight_rot_pkg::addr_t'(beat_cnt);

  // header registers steer the read wrap and the counters
  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      o_kw2      <= '0;
      o_kh2      <= '0;
      o_cin_1    <= '0;
      o_cols_1   <= '0;
      o_blocks_1 <= '0;
    end else if (i_ref_en) begin
      o_kw2      <= i_kw2;
      o_kh2      <= i_kh2;
      o_cin_1    <= i_cin_1;
      o_cols_1   <= i_cols_1;
      o_blocks_1 <= i_blocks_1;
    end
  end

  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (i_ref_en) begin  // new kernel starts at address 0
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (i_wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (i_rd_en) rd_ptr <= (rd_ptr == beats - 1'b1) ? '0 : rd_ptr + 1'b1;  // cyclic
    end
  end

  always_ff @(posedge aclk) begin
    if (i_wr_en) mem[wr_ptr] <= i_data;
  end

  assign o_rd_data = mem[rd_ptr];  // combinational read, registered in the reader

  // a packet longer than the bank would run off its end
  a_wr_in_range: assert property (@(posedge aclk) disable iff (!i_rst_n)
    i_wr_en |-> (int'(wr_ptr) < DEPTH));

  // the kernel announced by a header has to fit in the bank
  a_beats_fit: assert property (@(posedge aclk) disable iff (!i_rst_n)
    i_ref_en |=> (int'(beat_cnt) <= DEPTH));

endmodule

`default_nettype wire

// ==== weight_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_writer (
  input  wire        aclk,
  input  wire        i_rst_n,
  input  wire        i_s_tvalid,
  input  wire        i_s_tlast,
  input  wire  [1:0] i_done_read,
  output logic       o_s_tready,
  output logic [1:0] o_ref_en,
  output logic [1:0] o_wr_en,
  output logic [1:0] o_done_write
);

  weight_rot_pkg::w_state_e state;
  weight_rot_pkg::w_state_e state_next;

  logic       w_idx;  // bank being filled
  logic [1:0] w_sel;  // same, one-hot
  logic       s_hs;

  assign o_s_tready = (state == weight_rot_pkg::W_GET_REF) ||
                      (state == weight_rot_pkg::W_WRITE);
  assign s_hs       = i_s_tvalid && o_s_tready;
  assign w_sel      = w_idx ? 2'b10 : 2'b01;

  // first beat is the header, the rest are weight words
  assign o_ref_en = (state == weight_rot_pkg::W_GET_REF && s_hs) ? w_sel : 2'b00;
  assign o_wr_en  = (state == weight_rot_pkg::W_WRITE && s_hs) ? w_sel : 2'b00;

  always_comb begin
    state_next = state;
    case (state)
      weight_rot_pkg::W_IDLE:
        if (i_done_read[w_idx]) state_next = weight_rot_pkg::W_GET_REF;  // bank free
      weight_rot_pkg::W_GET_REF:
        if (s_hs) state_next = weight_rot_pkg::W_WRITE;
      weight_rot_pkg::W_WRITE:
        if (s_hs && i_s_tlast) state_next = weight_rot_pkg::W_SWITCH;
      weight_rot_pkg::W_SWITCH:
        state_next = weight_rot_pkg::W_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      state        <= weight_rot_pkg::W_IDLE;
      w_idx        <= 1'b0;
      o_done_write <= 2'b00;
    end else begin
      state <= state_next;
      // bank is about to be overwritten
      if (state == weight_rot_pkg::W_IDLE && i_done_read[w_idx]) begin
        o_done_write[w_idx] <= 1'b0;
      end
      if (state == weight_rot_pkg::W_SWITCH) begin
        o_done_write[w_idx] <= 1'b1;  // hand the full bank to the reader
        w_idx               <= ~w_idx;
      end
    end
  end

  // header load and word write share the input beat and must not overlap
  a_ref_wr_excl: assert property (@(posedge aclk) disable iff (!i_rst_n)
    !((|o_ref_en) && (|o_wr_en)));

endmodule

`default_nettype wire

// ==== weight_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_reader #(
  parameter int DATA_WIDTH = 32
) (
  input  wire                            aclk,
  input  wire                            i_rst_n,
  input  wire  [1:0]                     i_done_write,
  input  wire  [DATA_WIDTH-1:0]          i_rd_data0,
  input  wire  [DATA_WIDTH-1:0]          i_rd_data1,
  input  wire                            i_last,
  input  wire  weight_rot_pkg::tuser_t   i_user,
  input  wire                            i_m_tready,
  output logic [1:0]                     o_rd_en,
  output logic                           o_sel,
  output logic                           o_step,
  output logic [1:0]                     o_done_read,
  output logic                           o_m_tvalid,
  output logic [DATA_WIDTH-1:0]          o_m_tdata,
  output logic                           o_m_tlast,
  output weight_rot_pkg::tuser_t         o_m_tuser
);

  weight_rot_pkg::r_state_e state;
  weight_rot_pkg::r_state_e state_next;

  logic issued_last;  // final beat of this bank already in the output register
  logic m_hs;

  assign m_hs = o_m_tvalid && i_m_tready;

  // issue when the output register is empty or draining this cycle
  assign o_step  = (state == weight_rot_pkg::R_READ) && !issued_last &&
                   (!o_m_tvalid || i_m_tready);
  assign o_rd_en = o_step ? (o_sel ? 2'b10 : 2'b01) : 2'b00;

  always_comb begin
    state_next = state;
    case (state)
      weight_rot_pkg::R_IDLE:
        if (i_done_write[o_sel]) state_next = weight_rot_pkg::R_READ;
      weight_rot_pkg::R_READ:
        if (m_hs && o_m_tlast) state_next = weight_rot_pkg::R_SWITCH;
      weight_rot_pkg::R_SWITCH:
        state_next = weight_rot_pkg::R_IDLE;
      default:
        state_next = weight_rot_pkg::R_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      state       <= weight_rot_pkg::R_IDLE;
      o_sel       <= 1'b0;
      o_done_read <= 2'b11;  // both banks start out free for the writer
      issued_last <= 1'b0;
      o_m_tvalid  <= 1'b0;
    end else begin
      state <= state_next;
      if (state == weight_rot_pkg::R_IDLE && i_done_write[o_sel]) begin
        o_done_read[o_sel] <= 1'b0;  // lock the bank while rotating
      end
      if (state == weight_rot_pkg::R_SWITCH) begin
        o_done_read[o_sel] <= 1'b1;
        o_sel              <= ~o_sel;
        issued_last        <= 1'b0;
      end else if (o_step && i_last) begin
        issued_last <= 1'b1;
      end
      if (o_step) o_m_tvalid <= 1'b1;
      else if (m_hs) o_m_tvalid <= 1'b0;
    end
  end

  // output payload, loaded only on issue
  always_ff @(posedge aclk) begin
    if (o_step) begin
      o_m_tdata <= o_sel ? i_rd_data1 : i_rd_data0;
      o_m_tlast <= i_last;
      o_m_tuser <= i_user;
    end
  end

  a_hold_stall: assert property (@(posedge aclk) disable iff (!i_rst_n)
    (o_m_tvalid && !i_m_tready) |=> (o_m_tvalid && $stable(o_m_tdata) &&
                                     $stable(o_m_tlast) && $stable(o_m_tuser)));

endmodule

`default_nettype wire

// ==== rotation_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rotation_counter (
  input  wire                             aclk,
  input  wire                             i_rst_n,
  input  wire                             i_start,
  input  wire                             i_step,
  input  wire  weight_rot_pkg::kh2_t      i_kw2,
  input  wire  weight_rot_pkg::kh2_t      i_kh2,
  input  wire  weight_rot_pkg::cin_t      i_cin_1,
  input  wire  weight_rot_pkg::cols_t     i_cols_1,
  input  wire  weight_rot_pkg::blocks_t   i_blocks_1,
  output logic                            o_last,
  output weight_rot_pkg::tuser_t          o_user
);

  weight_rot_pkg::kh_t     kh_max;  // kernel height - 1
  weight_rot_pkg::kh_t     cnt_kh;
  weight_rot_pkg::cin_t    cnt_cin;
  weight_rot_pkg::cols_t   cnt_cols;
  weight_rot_pkg::blocks_t cnt_blocks;

  logic zero_kh;
  logic zero_cin;
  logic zero_cols;
  logic zero_blocks;
  logic wrap_cin;   // kh and cin both wrap on this step
  logic wrap_cols;  // kh, cin and cols all wrap on this step

  assign kh_max = {i_kh2, 1'b0};

  assign zero_kh     = (cnt_kh == '0);
  assign zero_cin    = (cnt_cin == '0);
  assign zero_cols   = (cnt_cols == '0);
  assign zero_blocks = (cnt_blocks == '0);

  assign wrap_cin  = zero_kh && zero_cin;
  assign wrap_cols = wrap_cin && zero_cols;

  // nested down-counters, kh is the innermost
  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      cnt_kh     <= '0;
      cnt_cin    <= '0;
      cnt_cols   <= '0;
      cnt_blocks <= '0;
    end else if (i_start) begin
      cnt_kh     <= kh_max;
      cnt_cin    <= i_cin_1;
      cnt_cols   <= i_cols_1;
      cnt_blocks <= i_blocks_1;
    end else if (i_step) begin
      cnt_kh <= zero_kh ? kh_max : cnt_kh - 1'b1;
      if (zero_kh) begin
        cnt_cin <= zero_cin ? i_cin_1 : cnt_cin - 1'b1;
      end
      if (wrap_cin) begin
        cnt_cols <= zero_cols ? i_cols_1 : cnt_cols - 1'b1;
      end
      if (wrap_cols) begin
        cnt_blocks <= zero_blocks ? i_blocks_1 : cnt_blocks - 1'b1;
      end
    end
  end

  // flags describe the beat issued in this cycle
  assign o_last = wrap_cols && zero_blocks;

  always_comb begin
    o_user = '0;
    o_user[weight_rot_pkg::I_KW2 +: weight_rot_pkg::BITS_KH2] = i_kw2;

    // first weight of a column
    o_user[weight_rot_pkg::I_IS_W_FIRST] = (cnt_cols == i_cols_1) &&
                                           (cnt_cin == i_cin_1) &&
                                           (cnt_kh == kh_max);

    o_user[weight_rot_pkg::I_IS_CIN_LAST] = wrap_cin;

    // column index cols-1-kw2 seen from the down-counter
    o_user[weight_rot_pkg::I_IS_COLS_1_K2] = (cnt_cols == weight_rot_pkg::cols_t'(i_kw2));

    o_user[weight_rot_pkg::I_IS_TOP_BLOCK]    = (cnt_blocks == i_blocks_1);
    o_user[weight_rot_pkg::I_IS_BOTTOM_BLOCK] = zero_blocks;
  end

endmodule

`default_nettype wire

// ==== axis_weight_rotator.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis_weight_rotator #(
  parameter int DATA_WIDTH = 32,
  parameter int DEPTH      = 48  // at most 64
) (
  input  wire                      aclk,
  input  wire                      i_rst_n,
  input  wire                      i_s_tvalid,
  input  wire                      i_s_tlast,
  input  wire  [DATA_WIDTH-1:0]    i_s_tdata,
  input  wire                      i_m_tready,
  output logic                     o_s_tready,
  output logic                     o_m_tvalid,
  output logic [DATA_WIDTH-1:0]    o_m_tdata,
  output logic                     o_m_tlast,
  output weight_rot_pkg::tuser_t   o_m_tuser
);

  // header layout from bit 0: kw2, kh2, cin_1, cols_1, blocks_1
  localparam int P_KH2    = weight_rot_pkg::BITS_KH2;
  localparam int P_CIN    = P_KH2 + weight_rot_pkg::BITS_KH2;
  localparam int P_COLS   = P_CIN + weight_rot_pkg::BITS_CIN;
  localparam int P_BLOCKS = P_COLS + weight_rot_pkg::BITS_COLS;

  weight_rot_pkg::kh2_t    s_kw2;
  weight_rot_pkg::kh2_t    s_kh2;
  weight_rot_pkg::cin_t    s_cin_1;
  weight_rot_pkg::cols_t   s_cols_1;
  weight_rot_pkg::blocks_t s_blocks_1;

  logic [1:0] ref_en, wr_en, rd_en, done_write, done_read;
  logic       sel, step, start, cnt_last;

  weight_rot_pkg::tuser_t  cnt_user;
  logic [DATA_WIDTH-1:0]   rd_data [2];
  weight_rot_pkg::kh2_t    b_kw2 [2];
  weight_rot_pkg::kh2_t    b_kh2 [2];
  weight_rot_pkg::cin_t    b_cin_1 [2];
  weight_rot_pkg::cols_t   b_cols_1 [2];
  weight_rot_pkg::blocks_t b_blocks_1 [2];

  assign s_kw2      = i_s_tdata[0 +: weight_rot_pkg::BITS_KH2];
  assign s_kh2      = i_s_tdata[P_KH2 +: weight_rot_pkg::BITS_KH2];
  assign s_cin_1    = i_s_tdata[P_CIN +: weight_rot_pkg::BITS_CIN];
  assign s_cols_1   = i_s_tdata[P_COLS +: weight_rot_pkg::BITS_COLS];
  assign s_blocks_1 = i_s_tdata[P_BLOCKS +: weight_rot_pkg::BITS_BLOCKS];

  // high only in the cycle the reader leaves R_IDLE
  assign start = done_write[sel] && done_read[sel];

  for (genvar i = 0; i < 2; i++) begin : g_bank
    weight_bank #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH)) u_bank (
      .aclk(aclk), .i_rst_n(i_rst_n),
      .i_ref_en(ref_en[i]), .i_wr_en(wr_en[i]), .i_rd_en(rd_en[i]), .i_data(i_s_tdata),
      .i_kw2(s_kw2), .i_kh2(s_kh2), .i_cin_1(s_cin_1),
      .i_cols_1(s_cols_1), .i_blocks_1(s_blocks_1),
      .o_rd_data(rd_data[i]), .o_kw2(b_kw2[i]), .o_kh2(b_kh2[i]),
      .o_cin_1(b_cin_1[i]), .o_cols_1(b_cols_1[i]), .o_blocks_1(b_blocks_1[i])
    );
  end

  weight_writer u_writer (
    .aclk(aclk), .i_rst_n(i_rst_n), .i_s_tvalid(i_s_tvalid), .i_s_tlast(i_s_tlast),
    .i_done_read(done_read), .o_s_tready(o_s_tready), .o_ref_en(ref_en),
    .o_wr_en(wr_en), .o_done_write(done_write)
  );

  weight_reader #(.DATA_WIDTH(DATA_WIDTH)) u_reader (
    .aclk(aclk), .i_rst_n(i_rst_n), .i_done_write(done_write),
    .i_rd_data0(rd_data[0]), .i_rd_data1(rd_data[1]), .i_last(cnt_last), .i_user(cnt_user),
    .i_m_tready(i_m_tready), .o_rd_en(rd_en), .o_sel(sel), .o_step(step),
    .o_done_read(done_read), .o_m_tvalid(o_m_tvalid), .o_m_tdata(o_m_tdata),
    .o_m_tlast(o_m_tlast), .o_m_tuser(o_m_tuser)
  );

  // counter follows the header of the bank being read
  rotation_counter u_counter (
    .aclk(aclk), .i_rst_n(i_rst_n), .i_start(start), .i_step(step),
    .i_kw2(b_kw2[sel]), .i_kh2(b_kh2[sel]), .i_cin_1(b_cin_1[sel]),
    .i_cols_1(b_cols_1[sel]), .i_blocks_1(b_blocks_1[sel]),
    .o_last(cnt_last), .o_user(cnt_user)
  );

endmodule

`default_nettype wire

// ==== tb_axis_weight_rotator.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axis_weight_rotator;

  localparam int DATA_WIDTH = 32;
  localparam int DEPTH      = 48;

  logic                   aclk       = 1'b0;
  logic                   i_rst_n    = 1'b0;
  logic                   i_s_tvalid = 1'b0;
  logic                   i_s_tlast  = 1'b0;
  logic [DATA_WIDTH-1:0]  i_s_tdata  = '0;
  logic                   i_m_tready = 1'b0;
  logic                   o_s_tready;
  logic                   o_m_tvalid;
  logic [DATA_WIDTH-1:0]  o_m_tdata;
  logic                   o_m_tlast;
  weight_rot_pkg::tuser_t o_m_tuser;

  integer seed = 25956;

  // stimulus words and headers with one row per packet
  logic [DATA_WIDTH-1:0]  word_mem [4][64];
  logic [DATA_WIDTH-1:0]  hdr_mem [4];
  int                     word_cnt [4];

  // reference queue of expected output beats filled before the run
  logic [DATA_WIDTH-1:0]  exp_data_mem [512];
  logic                   exp_last_mem [512];
  weight_rot_pkg::tuser_t exp_user_mem [512];
  logic [8:0]             exp_wr = '0;
  logic [8:0]             exp_rd = '0;
  logic [DATA_WIDTH-1:0]  exp_data;
  logic                   exp_last;
  weight_rot_pkg::tuser_t exp_user;

  int         kern_total [8];
  int         total_beats  = 0;
  int         beat_in_kern = 0;
  logic [2:0] pkts_in      = '0;  // packets fully accepted at the input
  logic [2:0] kern_out     = '0;  // kernels fully rotated out
  logic       overlap_seen = 1'b0;
  logic       end_check    = 1'b0;
  int         errors       = 0;
  int         errs_seen    = 0;
  int         n_tests      = 0;

  assign exp_data = exp_data_mem[exp_rd];
  assign exp_last = exp_last_mem[exp_rd];
  assign exp_user = exp_user_mem[exp_rd];

  always #4 aclk = ~aclk;

  axis_weight_rotator #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH)) i_dut (
    .aclk(aclk), .i_rst_n(i_rst_n),
    .i_s_tvalid(i_s_tvalid), .i_s_tlast(i_s_tlast), .i_s_tdata(i_s_tdata),
    .i_m_tready(i_m_tready), .o_s_tready(o_s_tready),
    .o_m_tvalid(o_m_tvalid), .o_m_tdata(o_m_tdata),
    .o_m_tlast(o_m_tlast), .o_m_tuser(o_m_tuser)
  );

  // sink ready about three cycles out of four
  always begin
    @(posedge aclk);
    #1;
    i_m_tready = (($random(seed) & 3) != 0);
  end

  always @(posedge aclk) begin
    if (i_rst_n && i_s_tvalid && o_s_tready && i_s_tlast) begin
      if (pkts_in == 3'd1 && kern_out == 3'd0) overlap_seen <= 1'b1;
      pkts_in <= pkts_in + 3'd1;
    end
    if (i_rst_n && o_m_tvalid && i_m_tready) begin
      exp_rd <= exp_rd + 9'd1;
      if (o_m_tlast) begin  // kernel boundary as the DUT marks it
        kern_out     <= kern_out + 3'd1;
        beat_in_kern <= 0;
      end else begin
        beat_in_kern <= beat_in_kern + 1;
      end
    end
  end

  a_reset_idle: assert property (@(posedge aclk) $rose(i_rst_n) |-> (!o_m_tvalid && !o_s_tready))
    else begin errors++; $display("outputs were not idle right after reset"); end

  a_no_early: assert property (@(posedge aclk) disable iff (!i_rst_n)
    o_m_tvalid |-> (pkts_in > kern_out))
    else begin errors++; $display("output beat came before its packet was fully sent"); end

  a_extra: assert property (@(posedge aclk) disable iff (!i_rst_n)
    (o_m_tvalid && i_m_tready) |-> (exp_rd < exp_wr))
    else begin errors++; $display("output beat beyond the end of the expected stream"); end

  a_data: assert property (@(posedge aclk) disable iff (!i_rst_n)
    (o_m_tvalid && i_m_tready) |-> (o_m_tdata == exp_data))
    else begin
      errors++;
      $display("mismatch at %0t ns: o_m_tdata got %h, expected %h",
               $time, $sampled(o_m_tdata), $sampled(exp_data));
    end

  a_last: assert property (@(posedge aclk) disable iff (!i_rst_n)
    (o_m_tvalid && i_m_tready) |-> (o_m_tlast == exp_last))
    else begin
      errors++;
      $display("mismatch at %0t ns: o_m_tlast got %b, expected %b",
               $time, $sampled(o_m_tlast), $sampled(exp_last));
    end

  a_user: assert property (@(posedge aclk) disable iff (!i_rst_n)
    (o_m_tvalid && i_m_tready) |-> (o_m_tuser == exp_user))
    else begin
      errors++;
      $display("mismatch at %0t ns: o_m_tuser got %b, expected %b",
               $time, $sampled(o_m_tuser), $sampled(exp_user));
    end

  a_beat_count: assert property (@(posedge aclk) disable iff (!i_rst_n)
    (o_m_tvalid && i_m_tready && o_m_tlast) |-> (beat_in_kern == kern_total[kern_out] - 1))
    else begin
      errors++;
      $display("mismatch at %0t ns: beat count got %0d, expected %0d", $time,
               $sampled(beat_in_kern) + 1, kern_total[$sampled(kern_out)]);
    end

  a_stall_hold: assert property (@(posedge aclk) disable iff (!i_rst_n)
    (o_m_tvalid && !i_m_tready) |=> (o_m_tvalid && $stable(o_m_tdata) &&
                                     $stable(o_m_tlast) && $stable(o_m_tuser)))
    else begin errors++; $display("output beat changed or vanished while stalled"); end

  a_drained: assert property (@(posedge aclk) end_check |-> (exp_rd == exp_wr))
    else begin errors++; $display("output stream ended with beats missing"); end

  a_overlap: assert property (@(posedge aclk) end_check |-> overlap_seen)
    else begin errors++; $display("second packet was not accepted during the first rotation"); end

  // words, header and expected output beats of one kernel
  task automatic build_kernel(input int p, input int kw2, input int kh2, input int cin_1,
                              input int cols_1, input int blocks_1);
    int k_len, w_cnt, total, i, n, kh, cin, col, blk;
    weight_rot_pkg::tuser_t u;
    k_len = 2 * kh2 + 1;
    w_cnt = k_len * (cin_1 + 1);
    total = w_cnt * (cols_1 + 1) * (blocks_1 + 1);
    hdr_mem[2'(p)]  = {16'($random(seed)), 4'(blocks_1), 4'(cols_1), 4'(cin_1),
                       2'(kh2), 2'(kw2)};  // upper half is junk
    word_cnt[2'(p)] = w_cnt;
    for (i = 0; i < w_cnt; i++) word_mem[2'(p)][6'(i)] = $random(seed);
    for (n = 0; n < total; n++) begin
      kh  = k_len - 1 - n % k_len;
      cin = cin_1 - (n / k_len) % (cin_1 + 1);
      col = cols_1 - (n / w_cnt) % (cols_1 + 1);
      blk = blocks_1 - n / (w_cnt * (cols_1 + 1));
      u = '0;
      u[weight_rot_pkg::I_KW2 +: weight_rot_pkg::BITS_KH2] = 2'(kw2);
      u[weight_rot_pkg::I_IS_W_FIRST]      = (col == cols_1) && (cin == cin_1) &&
                                             (kh == k_len - 1);
      u[weight_rot_pkg::I_IS_CIN_LAST]     = (kh == 0) && (cin == 0);
      u[weight_rot_pkg::I_IS_COLS_1_K2]    = (col == kw2);
      u[weight_rot_pkg::I_IS_TOP_BLOCK]    = (blk == blocks_1);
      u[weight_rot_pkg::I_IS_BOTTOM_BLOCK] = (blk == 0);
      exp_data_mem[exp_wr] = word_mem[2'(p)][6'(n % w_cnt)];  // words repeat per column
      exp_last_mem[exp_wr] = (n == total - 1);
      exp_user_mem[exp_wr] = u;
      exp_wr = exp_wr + 9'd1;
    end
    kern_total[3'(p)] = total;
    total_beats = total_beats + total;
  endtask

  // starts one ns after a rising edge and returns one ns after the accepting edge
  task automatic send_beat(input logic [DATA_WIDTH-1:0] data, input logic last);
    i_s_tvalid = 1'b1;
    i_s_tdata  = data;
    i_s_tlast  = last;
    @(negedge aclk);
    while (!o_s_tready) @(negedge aclk);
    @(posedge aclk);
    #1;
  endtask

  task automatic send_packet(input int p);
    int i;
    send_beat(hdr_mem[2'(p)], 1'b0);
    for (i = 0; i < word_cnt[2'(p)]; i++) begin
      send_beat(word_mem[2'(p)][6'(i)], i == word_cnt[2'(p)] - 1);
    end
    i_s_tvalid = 1'b0;
    i_s_tlast  = 1'b0;
  endtask

  task automatic wait_kernel(input int k);
    while (kern_out <= 3'(k)) @(posedge aclk);
  endtask

  task automatic report_test(input string name, input int beats);
    $display("test %-10s %4d beats  %0d errors", name, beats, errors - errs_seen);
    errs_seen = errors;
    n_tests++;
  endtask

  initial begin
    build_kernel(0, 1, 1, 3, 2, 1);  // 12 words, 72 beats
    build_kernel(1, 2, 2, 1, 3, 2);  // 10 words, 120 beats
    build_kernel(2, 0, 3, 5, 1, 0);  // 42 words, 84 beats
    repeat (8) @(posedge aclk);
    #1;
    i_rst_n = 1'b1;
    repeat (4) @(posedge aclk);
    #1;
    report_test("reset_idle", 0);
    fork
      begin
        send_packet(0);
        send_packet(1);  // goes into the other bank while kernel 0 rotates
        send_packet(2);
      end
      begin
        wait_kernel(0);
        report_test("kernel_0", kern_total[0]);
        wait_kernel(1);
        report_test("kernel_1", kern_total[1]);
        wait_kernel(2);
        report_test("kernel_2", kern_total[2]);
      end
    join
    repeat (4) @(posedge aclk);
    #1;
    end_check = 1'b1;
    @(posedge aclk);
    #1;
    end_check = 1'b0;
    @(posedge aclk);
    #1;
    report_test("stream_end", 0);
    $display("summary: %0d tests, %0d errors", n_tests, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog sized from the expected stream at 8 ns per cycle
  initial begin
    wait (total_beats > 0);
    repeat (40 * total_beats) @(posedge aclk);
    $display("timeout: the output stream did not finish in time");
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
weight_rot_pkg.sv
weight_bank.sv
weight_writer.sv
weight_reader.sv
rotation_counter.sv
axis_weight_rotator.sv
tb_axis_weight_rotator.sv

// ==== Makefile ====
TOP  := tb_axis_weight_rotator
SRCS := $(shell cat src.f)

.PHONY: all run clean

all: run

obj_dir/V$(TOP): src.f $(SRCS)
	verilator --binary --timing --assert --top-module $(TOP) -f src.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
